// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int    CLK_PERIOD      = 20;
    localparam int    PROG_WORDS      = 200;
    localparam addr_t LOOP_PC         = (PROG_WORDS - 1) * 4;
    localparam int    WATCHDOG_CYCLES = PROG_WORDS * 4 + 20;

    logic      clk;
    logic      rst_n;
    word_t     imem_rdata;
    imem_req_t imem_req;
    trace_t    trace;

    word_t       mem [0:255];
    word_t       ref_regs [0:31];
    addr_t       ref_pc;
    logic [31:0] lfsr_state;
    imem_req_t   pending_req;
    trace_t      expected;
    int          value_errors;
    int          timing_errors;
    int          loop_count;
    int          empty_cycles;
    logic        prev_taken;
    logic        seen_first;

    core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .trace      (trace)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Random bits and instruction encoding
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    task automatic build_program();
        word_t       sel;
        word_t       rd;
        word_t       rs1;
        word_t       rs2;
        word_t       imm;
        word_t       span;
        logic [12:0] off;
        // Unused words carry their own byte address
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 ^ word_t'(i * 4);
        end
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            take_bits(4, sel);
            take_bits(3, rd);
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(2, span);
            // Forward 1 to 4 words and never past the final loop
            span = span + 1;
            if (span > PROG_WORDS - 1 - i) begin
                span = PROG_WORDS - 1 - i;
            end
            off = span[12:0] << 2;
            case (sel)
                0:  mem[i] = enc_r(7'h00, 3'b000, rd[4:0], rs1[4:0], rs2[4:0]);
                1:  mem[i] = enc_r(7'h20, 3'b000, rd[4:0], rs1[4:0], rs2[4:0]);
                2:  mem[i] = enc_r(7'h00, 3'b111, rd[4:0], rs1[4:0], rs2[4:0]);
                3:  mem[i] = enc_r(7'h00, 3'b110, rd[4:0], rs1[4:0], rs2[4:0]);
                4:  mem[i] = enc_r(7'h00, 3'b100, rd[4:0], rs1[4:0], rs2[4:0]);
                5:  mem[i] = enc_r(7'h00, 3'b010, rd[4:0], rs1[4:0], rs2[4:0]);
                8, 14: begin
                    take_bits(20, imm);
                    mem[i] = {imm[19:0], rd[4:0], OPC_LUI};
                end
                9:  mem[i] = enc_b(3'b000, rs1[4:0], rs2[4:0], off);
                10: mem[i] = enc_b(3'b001, rs1[4:0], rs2[4:0], off);
                // Load opcode is outside the subset
                11, 15: begin
                    take_bits(25, imm);
                    mem[i] = {imm[24:0], 7'h03};
                end
                default: begin
                    take_bits(12, imm);
                    mem[i] = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
                end
            endcase
        end
        // BEQ x0, x0, 0
        mem[PROG_WORDS - 1] = 32'h0000_0063;
    endtask

    ////////////////////////////////////////
    // ISA reference model
    function automatic trace_t ref_step();
        trace_t   t;
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    result;
        word_t    imm;
        reg_idx_t rd;
        logic     has_result;
        logic     legal;
        logic     taken;
        instr      = mem[ref_pc[9:2]];
        rd         = instr[11:7];
        a          = ref_regs[instr[19:15]];
        b          = ref_regs[instr[24:20]];
        t          = '0;
        t.valid    = 1'b1;
        t.pc       = ref_pc;
        t.instr    = instr;
        t.rd       = rd;
        has_result = 1'b0;
        legal      = 1'b1;
        taken      = 1'b0;
        result     = '0;
        imm        = '0;
        case (instr[6:0])
            OPC_OP: begin
                has_result = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    {7'h00, 3'b000}: result = a + b;
                    {7'h20, 3'b000}: result = a - b;
                    {7'h00, 3'b010}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'b100}: result = a ^ b;
                    {7'h00, 3'b110}: result = a | b;
                    {7'h00, 3'b111}: result = a & b;
                    default:         legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                has_result = 1'b1;
                legal      = (instr[14:12] == 3'b000);
                result     = a + {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LUI: begin
                has_result = 1'b1;
                result     = {instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                if (instr[14:12] == 3'b000) begin
                    taken = (a == b);
                end else if (instr[14:12] == 3'b001) begin
                    taken = (a != b);
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
        endcase
        if (legal && has_result && rd != 5'd0) begin
            ref_regs[rd] = result;
            t.rd_data    = result;
            t.wrote_rd   = 1'b1;
        end
        t.illegal      = !legal;
        t.branch_taken = taken;
        ref_pc         = taken ? ref_pc + imm : ref_pc + 32'd4;
        return t;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus, memory and checking
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        imem_rdata    = '0;
        pending_req   = '0;
        lfsr_state    = 32'h38c4_480b;
        ref_pc        = RESET_PC;
        value_errors  = 0;
        timing_errors = 0;
        loop_count    = 0;
        empty_cycles  = 0;
        prev_taken    = 1'b0;
        seen_first    = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        build_program();
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // Memory answers the request of the previous cycle
    always @(negedge clk) begin
        pending_req = imem_req;
    end

    always @(posedge clk) begin
        #1;
        if (pending_req.valid) begin
            imem_rdata = mem[pending_req.addr[9:2]];
        end
    end

    always @(negedge clk) begin
        if (rst_n && trace.valid) begin
            expected = ref_step();
            check_addr("pc", expected.pc, trace.pc);
            check_word("instr", expected.instr, trace.instr);
            check_idx("rd", expected.rd, trace.rd);
            check_word("rd_data", expected.rd_data, trace.rd_data);
            check_flag("wrote_rd", expected.wrote_rd, trace.wrote_rd);
            check_flag("branch_taken", expected.branch_taken, trace.branch_taken);
            check_flag("illegal", expected.illegal, trace.illegal);
            // One empty slot after a taken branch and none otherwise
            if (seen_first && empty_cycles != (prev_taken ? 1 : 0)) begin
                timing_errors++;
                $display("At %0t the trace had %0d empty cycles before pc %h, expected %0d",
                         $time, empty_cycles, trace.pc, prev_taken ? 1 : 0);
            end
            seen_first   = 1'b1;
            prev_taken   = expected.branch_taken;
            empty_cycles = 0;
            if (expected.pc == LOOP_PC && expected.branch_taken) begin
                loop_count++;
            end
        end else if (rst_n && seen_first) begin
            empty_cycles++;
        end
    end

    initial begin
        wait (loop_count == 2);
        $display("Errors: %0d value mismatches, %0d timing mismatches",
                 value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: program did not reach its final loop");
        $display("Errors: %0d value mismatches, %0d timing mismatches",
                 value_errors, timing_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  core_pkg::alu_inputs_t alu_inputs,
    output core_pkg::word_t       alu_result
);
    import core_pkg::*;

    word_t sum;
    word_t diff;
    logic  less_than;

    assign sum       = alu_inputs.rs1 + alu_inputs.operand2;
    assign diff      = alu_inputs.rs1 - alu_inputs.operand2;
    assign less_than = $signed(alu_inputs.rs1) < $signed(alu_inputs.operand2);

    // Result select by op
    always_comb begin
        case (alu_inputs.op)
            OP_ADD,
            OP_ADDI: alu_result = sum;
            OP_SUB:  alu_result = diff;
            OP_AND:  alu_result = alu_inputs.rs1 & alu_inputs.operand2;
            OP_OR:   alu_result = alu_inputs.rs1 | alu_inputs.operand2;
            OP_XOR:  alu_result = alu_inputs.rs1 ^ alu_inputs.operand2;
            OP_SLT:  alu_result = {31'b0, less_than};
            // U-immediate already shifted in decode
            OP_LUI:  alu_result = alu_inputs.operand2;
            default: alu_result = '0;
        endcase
    end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  core_pkg::branch_inputs_t branch_inputs,
    output core_pkg::branch_result_t br_result_raw
);
    import core_pkg::*;

    logic equal;

    assign equal = (branch_inputs.rs1 == branch_inputs.rs2);

    // Target formed for every op and used only when taken
    assign br_result_raw.target = branch_inputs.pc + branch_inputs.imm;

    always_comb begin
        case (branch_inputs.op)
            OP_BEQ:  br_result_raw.taken = equal;
            OP_BNE:  br_result_raw.taken = ~equal;
            default: br_result_raw.taken = 1'b0;
        endcase
    end

endmodule

// ==== hw/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::word_t    imem_rdata,
    output core_pkg::imem_req_t imem_req,
    output core_pkg::trace_t   trace
);
    import core_pkg::*;

    fetch_packet_t  fetch_pkt;
    branch_result_t br_result;
    branch_result_t br_result_raw;

    reg_idx_t       rs1_idx;
    reg_idx_t       rs2_idx;
    word_t          rs1_data;
    word_t          rs2_data;

    alu_inputs_t    alu_inputs;
    word_t          alu_result;
    branch_inputs_t branch_inputs;

    rf_write_t      rf_wb;
    trace_t         retire;

    ////////////////////////////////////////
    // Fetch
    fetch fetch_block (.*);

    ////////////////////////////////////////
    // Decode, issue and writeback
    decode decode_block (.*);
    register_file register_file_block (.*);

    ////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (.*);
    branch_unit branch_unit_block (.*);

    ////////////////////////////////////////
    // Trace output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trace <= '0;
        end else begin
            trace <= retire;
        end
    end

    // The squashed fall-through leaves one empty slot after a taken branch
    branch_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        trace.valid && trace.branch_taken |-> !retire.valid)
        else $error("instruction retired right after taken branch at pc %h", trace.pc);

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////
    // Basic word types
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // Major opcode field values
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_BRANCH = 7'h63;

    // Decoded operation
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_ILLEGAL
    } op_t;

    ////////////////////////////////////////
    // Stage and unit records
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } fetch_packet_t;

    // operand2 is rs2 or the immediate, already selected
    typedef struct packed {
        op_t   op;
        word_t rs1;
        word_t operand2;
    } alu_inputs_t;

    typedef struct packed {
        op_t   op;
        addr_t pc;
        word_t rs1;
        word_t rs2;
        word_t imm;
    } branch_inputs_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } branch_result_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } rf_write_t;

    // One record per retired instruction
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    instr;
        reg_idx_t rd;
        word_t    rd_data;
        logic     wrote_rd;
        logic     branch_taken;
        logic     illegal;
    } trace_t;

endpackage

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::fetch_packet_t   fetch_pkt,
    input  core_pkg::word_t           rs1_data,
    input  core_pkg::word_t           rs2_data,
    input  core_pkg::word_t           alu_result,
    input  core_pkg::branch_result_t  br_result_raw,
    output core_pkg::reg_idx_t        rs1_idx,
    output core_pkg::reg_idx_t        rs2_idx,
    output core_pkg::alu_inputs_t     alu_inputs,
    output core_pkg::branch_inputs_t  branch_inputs,
    output core_pkg::branch_result_t  br_result,
    output core_pkg::rf_write_t       rf_wb,
    output core_pkg::trace_t          retire
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    op_t        op;
    logic       is_branch;
    logic       writes_rd;

    ////////////////////////////////////////
    // Field extraction
    assign opcode  = fetch_pkt.instr[6:0];
    assign rd      = fetch_pkt.instr[11:7];
    assign funct3  = fetch_pkt.instr[14:12];
    assign rs1_idx = fetch_pkt.instr[19:15];
    assign rs2_idx = fetch_pkt.instr[24:20];
    assign funct7  = fetch_pkt.instr[31:25];

    assign imm_i = {{20{fetch_pkt.instr[31]}}, fetch_pkt.instr[31:20]};
    assign imm_u = {fetch_pkt.instr[31:12], 12'b0};
    assign imm_b = {{19{fetch_pkt.instr[31]}}, fetch_pkt.instr[31], fetch_pkt.instr[7],
                    fetch_pkt.instr[30:25], fetch_pkt.instr[11:8], 1'b0};

    // Opcode, funct3 and funct7 to op
    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'h00) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b010:  op = OP_SLT;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_ILLEGAL;
                    endcase
                end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
                    op = OP_SUB;
                end
            end
            OPC_OP_IMM: if (funct3 == 3'b000) op = OP_ADDI;
            OPC_LUI:    op = OP_LUI;
            OPC_BRANCH: begin
                if (funct3 == 3'b000) op = OP_BEQ;
                else if (funct3 == 3'b001) op = OP_BNE;
            end
            default:    op = OP_ILLEGAL;
        endcase
    end

    assign is_branch = (op == OP_BEQ) || (op == OP_BNE);
    assign writes_rd = !is_branch && (op != OP_ILLEGAL);

    ////////////////////////////////////////
    // Issue to units
    assign alu_inputs.op       = op;
    assign alu_inputs.rs1      = rs1_data;
    assign alu_inputs.operand2 = (op == OP_ADDI) ? imm_i :
                                 (op == OP_LUI)  ? imm_u : rs2_data;

    assign branch_inputs.op  = op;
    assign branch_inputs.pc  = fetch_pkt.pc;
    assign branch_inputs.rs1 = rs1_data;
    assign branch_inputs.rs2 = rs2_data;
    assign branch_inputs.imm = imm_b;

    // Only a live branch may redirect fetch
    assign br_result.taken  = br_result_raw.taken & fetch_pkt.valid & is_branch;
    assign br_result.target = br_result_raw.target;

    ////////////////////////////////////////
    // Writeback and retire
    assign rf_wb.we   = fetch_pkt.valid & writes_rd & (rd != 5'd0);
    assign rf_wb.rd   = rd;
    assign rf_wb.data = alu_result;

    always_comb begin
        retire.valid        = fetch_pkt.valid;
        retire.pc           = fetch_pkt.pc;
        retire.instr        = fetch_pkt.instr;
        retire.rd           = rd;
        retire.rd_data      = rf_wb.we ? alu_result : '0;
        retire.wrote_rd     = rf_wb.we;
        retire.branch_taken = br_result.taken;
        retire.illegal      = fetch_pkt.valid & (op == OP_ILLEGAL);
    end

    branch_no_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(br_result_raw.taken && rf_wb.we))
        else $error("taken branch with register write at pc %h", fetch_pkt.pc);

endmodule

// ==== hw/fetch.sv ====
`timescale 1ns/1ps

module fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::branch_result_t br_result,
    input  core_pkg::word_t          imem_rdata,
    output core_pkg::imem_req_t      imem_req,
    output core_pkg::fetch_packet_t  fetch_pkt
);
    import core_pkg::*;

    addr_t pc;
    addr_t pc_next;
    addr_t inflight_addr;
    logic  run;
    logic  inflight_valid;
    logic  squash;

    ////////////////////////////////////////
    // Program counter
    assign pc_next = br_result.taken ? br_result.target : pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run            <= 1'b0;
            pc             <= RESET_PC;
            inflight_valid <= 1'b0;
            squash         <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                pc <= pc_next;
            end
            inflight_valid <= run;
            // Fall-through response lands next cycle
            squash         <= br_result.taken;
        end
    end

    // Address of the word coming back from memory
    always_ff @(posedge clk) begin
        inflight_addr <= pc;
    end

    ////////////////////////////////////////
    // Memory request and returned packet
    assign imem_req.valid = run;
    assign imem_req.addr  = pc;

    assign fetch_pkt.valid = inflight_valid & ~squash;
    assign fetch_pkt.pc    = inflight_addr;
    assign fetch_pkt.instr = imem_rdata;

    // Branch targets must keep the PC on a word boundary
    pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc);

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_idx_t  rs1_idx,
    input  core_pkg::reg_idx_t  rs2_idx,
    input  core_pkg::rf_write_t rf_wb,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    // Storage for x1 to x31 only
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wb.we && rf_wb.rd != 5'd0) begin
            regs[rf_wb.rd] <= rf_wb.data;
        end
    end

    ////////////////////////////////////////
    // Combinational read ports
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// ==== sim.f ====
hw/core_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/register_file.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/core.sv
bench/core_tb.sv
